// ==== project.f ====
hdl/sramMapPkg.sv
hdl/colorPkg.sv
hdl/rowSequencer.sv
hdl/sramPort.sv
hdl/chromaUpsampler.sv
hdl/colorConverter.sv
hdl/rgbPacker.sv
hdl/yuvToRgb.sv
testbench/tbSramModel.sv
testbench/tbYuvToRgb.sv

// ==== run.sh ====
#!/bin/bash
# compile and run the YUV to RGB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tbYuvToRgb -o simYuvToRgb
if [ $? -ne 0 ]; then
	echo "compile step returned an error"
	exit 1
fi

./obj_dir/simYuvToRgb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== testbench/tbYuvToRgb.sv ====
`timescale 1ns/1ns

module tbYuvToRgb
	import sramMapPkg::*, colorPkg::*;
();

	localparam int Pairs = 8;
	localparam int Words = 3 * Pairs;
	localparam sramAddr_t YBase = 18'd0;
	localparam sramAddr_t UBase = 18'd38400;
	localparam sramAddr_t VBase = 18'd57600;
	localparam sramAddr_t RgbBase = 18'd146944;
	// watchdog budget, tests x pairs x cycles per pair x period
	localparam int TestCount = 5;
	localparam int CyclesPerPair = 40;
	localparam int ClockPeriod = 20;
	localparam int TimeLimit = TestCount * Pairs * CyclesPerPair * ClockPeriod;

	logic Clock, resetn, start, done, sramWeN;
	sramWord_u readData, sramWriteData;
	sramAddr_t sramAddress;
	logic loadEn;
	sramAddr_t loadAddress;
	sramWord_u loadWord;

	// current row, two Y per pair and one U and V per pair
	sample_t yRow [2 * Pairs];
	sample_t uRow [Pairs];
	sample_t vRow [Pairs];

	// what the last row did on the bus
	sramAddr_t wrLog [Words];
	int wrCount, countAtDone, extraWrites;
	logic doneBeforeStart, doneAfterStart, doneAfterReset;
	int testErrors, checkErrors, testsRun, testsFailed;
	logic [15:0] lfsr;

	yuvToRgb #(.YBase(YBase), .UBase(UBase), .VBase(VBase), .RgbBase(RgbBase),
		.PairsPerRow(Pairs)) uut (
		.Clock(Clock), .resetn(resetn), .start(start), .readData(readData),
		.done(done), .sramAddress(sramAddress), .sramWriteData(sramWriteData),
		.sramWeN(sramWeN));

	tbSramModel sram (
		.Clock(Clock), .resetn(resetn), .address(sramAddress),
		.writeData(sramWriteData), .weN(sramWeN), .readData(readData),
		.loadEn(loadEn), .loadAddress(loadAddress), .loadWord(loadWord));

	initial begin
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = ~Clock;
	end

	// taps 16 14 13 11, one step per bit
	function automatic logic nextBit();
		logic fb;
		nextBit = lfsr[15];
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
	endfunction

	function automatic sample_t randomSample();
		sample_t s;
		for (int i = 0; i < 8; i++)
			s = {s[6:0], nextBit()};
		return s;
	endfunction

	// chroma sample, index held inside the row at both ends
	function automatic int chromaSample(input logic isV, input int idx);
		int k;
		k = (idx < 0) ? 0 : ((idx > Pairs - 1) ? Pairs - 1 : idx);
		return isV ? int'(vRow[k]) : int'(uRow[k]);
	endfunction

	// interpolated chroma between pair p and p+1, centred on zero
	function automatic int halfPel(input logic isV, input int p);
		int sum;
		sum = 21 * (chromaSample(isV, p - 2) + chromaSample(isV, p + 3))
			- 52 * (chromaSample(isV, p - 1) + chromaSample(isV, p + 2))
			+ 159 * (chromaSample(isV, p) + chromaSample(isV, p + 1));
		return ((sum + 128) >>> 8) - 128;
	endfunction

	// colour sits in bits 31..16
	function automatic sample_t clampColor(input int acc);
		if (acc < 0)
			return 8'd0;
		if ((acc >>> 16) > 255)
			return 8'd255;
		return sample_t'(acc >>> 16);
	endfunction

	function automatic rgbPixel_t toRgb(input int y, input int u, input int v);
		int luma;
		rgbPixel_t px;
		luma = 76284 * (y - 16);
		px.r = clampColor(luma + 104595 * v);
		px.g = clampColor(luma - 25624 * u - 53281 * v);
		px.b = clampColor(luma + 132251 * u);
		return px;
	endfunction

	// word w of the row, three per pair
	function automatic sramWord_u expectedWord(input int w);
		int p;
		rgbPixel_t even, odd;
		sramWord_u word;
		p = w / 3;
		even = toRgb(int'(yRow[2 * p]), int'(uRow[p]) - 128, int'(vRow[p]) - 128);
		odd = toRgb(int'(yRow[2 * p + 1]), halfPel(1'b0, p), halfPel(1'b1, p));
		case (w % 3)
			0: word.raw = {even.r, even.g};
			1: word.raw = {even.b, odd.r};
			default: word.raw = {odd.g, odd.b};
		endcase
		return word;
	endfunction

	function automatic sramWord_u storedWord(input int w);
		return sramWord_u'(sram.mem[RgbBase + sramAddr_t'(w)]);
	endfunction

	// background for the RGB region, never a valid result by chance
	function automatic logic [15:0] fillWord(input sramAddr_t a);
		return a[15:0] ^ a[17:2];
	endfunction

	task automatic checkWord(input string name, input sramWord_u expected,
		input sramWord_u actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %h actual %h", name, expected.raw, actual.raw);
			testErrors++;
		end
	endtask

	task automatic checkAddress(input string name, input sramAddr_t expected,
		input sramAddr_t actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %0d actual %0d", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %b actual %b", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic reportProblem(input string msg);
		$display("%s", msg);
		testErrors++;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (testErrors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d checks wrong", name, testErrors);
			testsFailed++;
			checkErrors += testErrors;
		end
		testErrors = 0;
	endtask

	task automatic storeWord(input sramAddr_t a, input logic [15:0] w);
		@(posedge Clock);
		loadEn <= 1'b1;
		loadAddress <= a;
		loadWord.raw <= w;
	endtask

	task automatic loadRow();
		for (int p = 0; p < Pairs; p++)
			storeWord(YBase + sramAddr_t'(p), {yRow[2 * p], yRow[2 * p + 1]});
		for (int k = 0; k < Pairs / 2; k++) begin
			storeWord(UBase + sramAddr_t'(k), {uRow[2 * k], uRow[2 * k + 1]});
			storeWord(VBase + sramAddr_t'(k), {vRow[2 * k], vRow[2 * k + 1]});
		end
		// old results must not survive into this row
		for (int w = 0; w < Words; w++)
			storeWord(RgbBase + sramAddr_t'(w), fillWord(RgbBase + sramAddr_t'(w)));
		@(posedge Clock);
		loadEn <= 1'b0;
	endtask

	task automatic randomRow();
		for (int i = 0; i < 2 * Pairs; i++)
			yRow[i] = randomSample();
		for (int i = 0; i < Pairs; i++) begin
			uRow[i] = randomSample();
			vRow[i] = randomSample();
		end
	endtask

	// load, pulse start, log writes until done
	task automatic runRow();
		loadRow();
		wrCount = 0;
		doneBeforeStart = done;
		@(posedge Clock);
		start <= 1'b1;
		@(posedge Clock);
		start <= 1'b0;
		@(posedge Clock);
		doneAfterStart = done;
		while (!done) begin
			if (!sramWeN) begin
				if (wrCount < Words)
					wrLog[wrCount] = sramAddress;
				wrCount++;
			end
			@(posedge Clock);
		end
		countAtDone = wrCount;
		// bus should stay quiet once done is up
		extraWrites = 0;
		repeat (4) begin
			@(posedge Clock);
			if (!sramWeN)
				extraWrites++;
		end
	endtask

	task automatic checkWords(input string label);
		for (int w = 0; w < Words; w++)
			checkWord($sformatf("%s word %0d", label, w), expectedWord(w), storedWord(w));
	endtask

	task automatic checkAddresses();
		if (wrCount != Words)
			reportProblem($sformatf("%0d writes seen where %0d were expected", wrCount, Words));
		for (int w = 0; w < Words && w < wrCount; w++)
			checkAddress($sformatf("write address %0d", w), RgbBase + sramAddr_t'(w), wrLog[w]);
	endtask

	// source planes must read back as loaded
	task automatic checkPlanes();
		sramWord_u want;
		for (int p = 0; p < Pairs; p++) begin
			want.raw = {yRow[2 * p], yRow[2 * p + 1]};
			checkWord($sformatf("Y plane word %0d", p), want,
				sramWord_u'(sram.mem[YBase + sramAddr_t'(p)]));
		end
		for (int k = 0; k < Pairs / 2; k++) begin
			want.raw = {uRow[2 * k], uRow[2 * k + 1]};
			checkWord($sformatf("U plane word %0d", k), want,
				sramWord_u'(sram.mem[UBase + sramAddr_t'(k)]));
			want.raw = {vRow[2 * k], vRow[2 * k + 1]};
			checkWord($sformatf("V plane word %0d", k), want,
				sramWord_u'(sram.mem[VBase + sramAddr_t'(k)]));
		end
	endtask

	initial begin
		#(TimeLimit);
		$display("watchdog: run did not finish within %0d ns", TimeLimit);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		sramWord_u got;
		lfsr = 16'd26;
		testErrors = 0;
		checkErrors = 0;
		testsRun = 0;
		testsFailed = 0;
		resetn <= 1'b0;
		start <= 1'b0;
		loadEn <= 1'b0;
		loadAddress <= '0;
		loadWord <= '0;
		repeat (3) @(posedge Clock);
		resetn <= 1'b1;
		@(posedge Clock);
		doneAfterReset = done;

		// black level with zero chroma gives black
		for (int i = 0; i < 2 * Pairs; i++)
			yRow[i] = 8'd16;
		for (int i = 0; i < Pairs; i++) begin
			uRow[i] = 8'd128;
			vRow[i] = 8'd128;
		end
		runRow();
		for (int w = 0; w < Words; w++)
			checkWord($sformatf("neutral word %0d", w), '0, storedWord(w));
		finishTest("neutral row");

		randomRow();
		runRow();
		checkWords("random");
		finishTest("random row");

		// bright red half, then dark blue-less half
		for (int p = 0; p < Pairs; p++) begin
			if (p < Pairs / 2) begin
				yRow[2 * p] = 8'd255;
				yRow[2 * p + 1] = 8'd255;
				uRow[p] = 8'd128;
				vRow[p] = 8'd255;
			end else begin
				yRow[2 * p] = 8'd0;
				yRow[2 * p + 1] = 8'd0;
				uRow[p] = 8'd0;
				vRow[p] = 8'd128;
			end
		end
		runRow();
		checkWords("clipping");
		got = storedWord(0);
		checkFlag("first red clipped to 255", 1'b1, got.bytes.hi == 8'd255);
		got = storedWord(Words - 1);
		checkFlag("last blue clipped to 0", 1'b1, got.bytes.lo == 8'd0);
		finishTest("clipping");

		randomRow();
		runRow();
		checkAddresses();
		checkPlanes();
		finishTest("address range");

		// second start after a finished row
		randomRow();
		runRow();
		checkFlag("done low after reset", 1'b0, doneAfterReset);
		checkFlag("done high before restart", 1'b1, doneBeforeStart);
		checkFlag("done clears on start", 1'b0, doneAfterStart);
		checkFlag("done only after last write", 1'b1, countAtDone == Words);
		if (extraWrites != 0)
			reportProblem($sformatf("%0d writes happened after done was set", extraWrites));
		checkAddresses();
		checkWords("restart");
		finishTest("done and restart");

		$display("tests %0d, failed %0d, wrong checks %0d", testsRun, testsFailed, checkErrors);
		if (testsFailed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== testbench/tbSramModel.sv ====
`timescale 1ns/1ns

module tbSramModel import sramMapPkg::*; (
	input logic Clock,
	input logic resetn,
	input sramAddr_t address,
	input sramWord_u writeData,
	input logic weN,
	output sramWord_u readData,
	input logic loadEn,
	input sramAddr_t loadAddress,
	input sramWord_u loadWord
);

	// whole 256K word array, read back by the testbench
	logic [15:0] mem [0:262143];

	// testbench loads only while the DUT is idle
	always_ff @(posedge Clock) begin
		if (loadEn)
			mem[loadAddress] <= loadWord.raw;
		else if (!weN)
			mem[address] <= writeData.raw;
	end

	// address is registered by the DUT on one edge
	// the word is ready for the DUT two edges after that
	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn)
			readData <= '0;
		else
			readData <= sramWord_u'(mem[address]);
	end

endmodule

// ==== hdl/yuvToRgb.sv ====
`timescale 1ns/1ns

module yuvToRgb import sramMapPkg::*, colorPkg::*; #(
	parameter sramAddr_t YBase = 18'd0,
	parameter sramAddr_t UBase = 18'd38400,
	parameter sramAddr_t VBase = 18'd57600,
	parameter sramAddr_t RgbBase = 18'd146944,
	// must be even, one U and V word spans two pairs
	parameter int PairsPerRow = 160
) (
	input logic Clock,
	input logic resetn,
	input logic start,
	input sramWord_u readData,
	output logic done,
	output sramAddr_t sramAddress,
	output sramWord_u sramWriteData,
	output logic sramWeN
);

	readReq_t readReq;
	readRet_t readRet;
	logic reqValid, reqReady, retValid;
	sramWord_u chromaWordU, chromaWordV, lumaWord, wrWord;
	logic chromaValid, chromaReady, lumaValid, lumaReady;
	chromaPair_t chromaPair;
	logic pairValid, pairReady;
	rgbPair_t rgbPair;
	logic rgbValid, rgbReady;
	sramAddr_t wrAddress;
	logic wrValid, wrReady, rowWritten;

	rowSequencer #(.YBase(YBase), .UBase(UBase), .VBase(VBase),
		.PairsPerRow(PairsPerRow)) sequencer (.*);

	sramPort port (.*);

	chromaUpsampler #(.PairsPerRow(PairsPerRow)) upsampler (.*);

	colorConverter converter (.*);

	rgbPacker #(.RgbBase(RgbBase), .PairsPerRow(PairsPerRow)) packer (.*);

endmodule

// ==== hdl/rgbPacker.sv ====
`timescale 1ns/1ns

module rgbPacker import sramMapPkg::*, colorPkg::*; #(
	parameter sramAddr_t RgbBase = 18'd146944,
	parameter int PairsPerRow = 160
) (
	input logic Clock,
	input logic resetn,
	input rgbPair_t rgbPair,
	input logic rgbValid,
	output logic rgbReady,
	output sramAddr_t wrAddress,
	output sramWord_u wrWord,
	output logic wrValid,
	input logic wrReady,
	output logic rowWritten
);

	localparam sramAddr_t LastWord = sramAddr_t'(3 * PairsPerRow - 1);

	// which of the three words of a pair goes next
	logic [1:0] phase;
	sramAddr_t wordCount;
	logic wrMove;

	assign wrValid = rgbValid;
	assign wrMove = wrValid && wrReady;
	// the pair is released with its third word
	assign rgbReady = wrReady && (phase == 2'd2);
	assign wrAddress = RgbBase + wordCount;

	always_comb begin
		case (phase)
			2'd0: wrWord.bytes = '{hi: rgbPair.p0.r, lo: rgbPair.p0.g};
			2'd1: wrWord.bytes = '{hi: rgbPair.p0.b, lo: rgbPair.p1.r};
			default: wrWord.bytes = '{hi: rgbPair.p1.g, lo: rgbPair.p1.b};
		endcase
	end

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			phase <= 2'd0;
			wordCount <= '0;
			rowWritten <= 1'b0;
		end else begin
			rowWritten <= 1'b0;
			if (wrMove) begin
				phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
				// wrap for the next row after the last word
				if (wordCount == LastWord) begin
					wordCount <= '0;
					rowWritten <= 1'b1;
				end else begin
					wordCount <= wordCount + 18'd1;
				end
			end
		end
	end

endmodule

// ==== hdl/colorConverter.sv ====
`timescale 1ns/1ns

module colorConverter import sramMapPkg::*, colorPkg::*; (
	input logic Clock,
	input logic resetn,
	input sramWord_u lumaWord,
	input logic lumaValid,
	output logic lumaReady,
	input chromaPair_t chromaPair,
	input logic pairValid,
	output logic pairReady,
	output rgbPair_t rgbPair,
	output logic rgbValid,
	input logic rgbReady
);

	yuvPair_t inPair;
	logic stall, accept;
	// one valid bit per stage
	logic v1, v2, v3;

	// stage 1, offset luma and chroma as two pixels
	fixed_t yS1 [2];
	fixed_t uS1 [2];
	fixed_t vS1 [2];
	// stage 2 products
	fixed_t yT [2];
	fixed_t rv [2];
	fixed_t gu [2];
	fixed_t gv [2];
	fixed_t bu [2];
	// stage 3 sums
	fixed_t rSum [2];
	fixed_t gSum [2];
	fixed_t bSum [2];

	// colour lands in bits 23..16, negative or overflow is clipped
	function automatic sample_t clip(input fixed_t x);
		if (x[31])
			return 8'd0;
		else if (x[30:24] != 7'd0)
			return 8'd255;
		else
			return x[23:16];
	endfunction

	assign inPair = '{y0: lumaWord.bytes.hi, y1: lumaWord.bytes.lo, chroma: chromaPair};

	// whole pipe freezes while the packer is busy
	assign stall = rgbValid && !rgbReady;
	assign lumaReady = pairValid && !stall;
	assign pairReady = lumaValid && !stall;
	assign accept = lumaValid && pairValid && !stall;

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
			rgbValid <= 1'b0;
		end else if (!stall) begin
			v1 <= accept;
			v2 <= v1;
			v3 <= v2;
			rgbValid <= v3;
		end
	end

	always_ff @(posedge Clock) begin
		if (!stall) begin
			yS1[0] <= fixed_t'({24'd0, inPair.y0}) - LumaOffset;
			yS1[1] <= fixed_t'({24'd0, inPair.y1}) - LumaOffset;
			uS1[0] <= inPair.chroma.uEven;
			uS1[1] <= inPair.chroma.uOdd;
			vS1[0] <= inPair.chroma.vEven;
			vS1[1] <= inPair.chroma.vOdd;
			for (int i = 0; i < 2; i++) begin
				yT[i] <= CoefY * yS1[i];
				rv[i] <= CoefRv * vS1[i];
				gu[i] <= CoefGu * uS1[i];
				gv[i] <= CoefGv * vS1[i];
				bu[i] <= CoefBu * uS1[i];
				rSum[i] <= yT[i] + rv[i];
				gSum[i] <= yT[i] + gu[i] + gv[i];
				bSum[i] <= yT[i] + bu[i];
			end
			rgbPair.p0.r <= clip(rSum[0]);
			rgbPair.p0.g <= clip(gSum[0]);
			rgbPair.p0.b <= clip(bSum[0]);
			rgbPair.p1.r <= clip(rSum[1]);
			rgbPair.p1.g <= clip(gSum[1]);
			rgbPair.p1.b <= clip(bSum[1]);
		end
	end

endmodule

// ==== hdl/chromaUpsampler.sv ====
`timescale 1ns/1ns

module chromaUpsampler import sramMapPkg::*, colorPkg::*; #(
	parameter int PairsPerRow = 160
) (
	input logic Clock,
	input logic resetn,
	input sramWord_u chromaWordU,
	input sramWord_u chromaWordV,
	input logic chromaValid,
	output logic chromaReady,
	output chromaPair_t chromaPair,
	output logic pairValid,
	input logic pairReady
);

	localparam int CountW = $clog2(PairsPerRow + 8);

	typedef enum logic [1:0] {Fill, Calc, Emit} upState_e;

	upState_e state;
	// phase bit 1 picks V, bit 0 the right half of the window
	logic [1:0] phase;
	// samples shifted in so far and the pair being built
	logic [CountW-1:0] cnt, pairIdx;
	logic [1:0] pendCnt;
	sramWord_u pendU, pendV;
	// window holds samples pairIdx-2 .. pairIdx+3
	sample_t winU [6];
	sample_t winV [6];
	sample_t nextU, nextV, inU, inV;
	sample_t opA [3];
	fixed_t coef [3];
	fixed_t acc, mac, odd;
	logic windowReady, pad, take;

	// word waits here until both samples are used
	assign chromaReady = (pendCnt == 2'd0);
	assign nextU = (pendCnt == 2'd2) ? pendU.bytes.hi : pendU.bytes.lo;
	assign nextV = (pendCnt == 2'd2) ? pendV.bytes.hi : pendV.bytes.lo;

	assign windowReady = (cnt == pairIdx + CountW'(4));
	// past the row end the last sample repeats
	assign pad = !windowReady && (cnt >= CountW'(PairsPerRow));
	assign take = (state == Fill) && !windowReady && !pad && (pendCnt != 2'd0);
	assign inU = pad ? winU[5] : nextU;
	assign inV = pad ? winV[5] : nextV;

	assign pairValid = (state == Emit);

	// three multipliers cover half a window per cycle
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			if (phase[0])
				opA[i] = phase[1] ? winV[i + 3] : winU[i + 3];
			else
				opA[i] = phase[1] ? winV[i] : winU[i];
		end
		coef[0] = phase[0] ? Tap1 : Tap5;
		coef[1] = Tap3;
		coef[2] = phase[0] ? Tap5 : Tap1;
		mac = '0;
		for (int i = 0; i < 3; i++)
			mac = mac + fixed_t'({24'd0, opA[i]}) * coef[i];
		odd = ((acc + mac + FilterRound) >>> FilterShift) - ChromaOffset;
	end

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			state <= Fill;
			phase <= 2'd0;
			cnt <= '0;
			pairIdx <= '0;
			pendCnt <= 2'd0;
		end else begin
			if (chromaValid && chromaReady)
				pendCnt <= 2'd2;
			else if (take)
				pendCnt <= pendCnt - 2'd1;
			case (state)
				Fill: begin
					if (windowReady) begin
						state <= Calc;
						phase <= 2'd0;
					end else if (pad || take) begin
						cnt <= cnt + CountW'(1);
					end
				end
				Calc: begin
					phase <= phase + 2'd1;
					if (phase == 2'd3)
						state <= Emit;
				end
				default: begin
					if (pairReady) begin
						state <= Fill;
						// row finished, start clean for the next one
						if (pairIdx == CountW'(PairsPerRow - 1)) begin
							pairIdx <= '0;
							cnt <= '0;
						end else begin
							pairIdx <= pairIdx + CountW'(1);
						end
					end
				end
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge Clock) begin
		if (chromaValid && chromaReady) begin
			pendU <= chromaWordU;
			pendV <= chromaWordV;
		end
		if (state == Fill && (pad || take)) begin
			// first sample replicates across the left edge
			for (int i = 0; i < 6; i++) begin
				if (cnt == '0) begin
					winU[i] <= inU;
					winV[i] <= inV;
				end else if (i < 5) begin
					winU[i] <= winU[i + 1];
					winV[i] <= winV[i + 1];
				end else begin
					winU[i] <= inU;
					winV[i] <= inV;
				end
			end
		end
		if (state == Calc) begin
			acc <= mac;
			case (phase)
				2'd1: begin
					chromaPair.uOdd <= odd;
					chromaPair.uEven <= fixed_t'({24'd0, winU[2]}) - ChromaOffset;
				end
				2'd3: begin
					chromaPair.vOdd <= odd;
					chromaPair.vEven <= fixed_t'({24'd0, winV[2]}) - ChromaOffset;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== hdl/sramPort.sv ====
`timescale 1ns/1ns

module sramPort import sramMapPkg::*; (
	input logic Clock,
	input logic resetn,
	input readReq_t readReq,
	input logic reqValid,
	output logic reqReady,
	input sramAddr_t wrAddress,
	input sramWord_u wrWord,
	input logic wrValid,
	output logic wrReady,
	output readRet_t readRet,
	output logic retValid,
	output sramAddr_t sramAddress,
	output sramWord_u sramWriteData,
	output logic sramWeN,
	input sramWord_u readData
);

	// tag delay line, index 1 lines up with readData
	logic [1:0] tagValid;
	plane_e tagPlane [2];
	logic readGo;

	// writes always win the port
	assign wrReady = 1'b1;
	assign reqReady = !wrValid;
	assign readGo = reqValid && reqReady;

	assign retValid = tagValid[1];
	assign readRet = '{plane: tagPlane[1], word: readData};

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			sramAddress <= '0;
			sramWriteData <= '0;
			sramWeN <= 1'b1;
			tagValid <= 2'b00;
		end else begin
			sramWeN <= 1'b1;
			if (wrValid) begin
				sramAddress <= wrAddress;
				sramWriteData <= wrWord;
				sramWeN <= 1'b0;
			end else if (readGo) begin
				sramAddress <= readReq.address;
			end
			tagValid <= {tagValid[0], readGo};
		end
	end

	// plane tags are payload and follow the valid bits
	always_ff @(posedge Clock) begin
		tagPlane[0] <= readReq.plane;
		tagPlane[1] <= tagPlane[0];
	end

endmodule

// ==== hdl/rowSequencer.sv ====
`timescale 1ns/1ns

module rowSequencer import sramMapPkg::*; #(
	parameter sramAddr_t YBase = 18'd0,
	parameter sramAddr_t UBase = 18'd38400,
	parameter sramAddr_t VBase = 18'd57600,
	parameter int PairsPerRow = 160
) (
	input logic Clock,
	input logic resetn,
	input logic start,
	output readReq_t readReq,
	output logic reqValid,
	input logic reqReady,
	input readRet_t readRet,
	input logic retValid,
	output sramWord_u chromaWordU,
	output sramWord_u chromaWordV,
	output logic chromaValid,
	input logic chromaReady,
	output sramWord_u lumaWord,
	output logic lumaValid,
	input logic lumaReady,
	input logic rowWritten,
	output logic done
);

	// one U and one V word cover two pairs
	localparam sramAddr_t ULast = UBase + sramAddr_t'(PairsPerRow / 2);
	// luma words that may be in flight or queued at once
	localparam int LumaDepth = 4;

	logic busy;
	// position in the U, V, Y, Y issue order
	logic [1:0] sel;
	sramAddr_t uAddr, vAddr, yAddr;
	// U and V credit, held from issue until the word moves on
	logic occU, occV;
	logic fullU, fullV;
	// Y reads in flight or queued, and Y words queued
	logic [2:0] occY, heldY;
	// luma waits here while the filter runs ahead on chroma
	sramWord_u lumaBuf [LumaDepth];
	logic [1:0] lumaHead, lumaTail;
	logic credit, issuing, issue, issueY, retY;
	logic chromaMove, lumaMove;

	always_comb begin
		case (sel)
			2'd0: begin
				readReq = '{plane: PlaneU, address: uAddr};
				credit = !occU;
			end
			2'd1: begin
				readReq = '{plane: PlaneV, address: vAddr};
				credit = !occV;
			end
			default: begin
				readReq = '{plane: PlaneY, address: yAddr};
				credit = (occY != 3'(LumaDepth));
			end
		endcase
	end

	// a group is only opened while U words remain
	assign issuing = busy && (sel != 2'd0 || uAddr != ULast);
	assign reqValid = issuing && credit;
	assign issue = reqValid && reqReady;
	assign issueY = issue && sel[1];
	assign retY = retValid && (readRet.plane == PlaneY);

	assign chromaValid = fullU && fullV;
	assign lumaValid = (heldY != 3'd0);
	assign lumaWord = lumaBuf[lumaHead];
	assign chromaMove = chromaValid && chromaReady;
	assign lumaMove = lumaValid && lumaReady;

	always_ff @(posedge Clock or negedge resetn) begin
		if (!resetn) begin
			busy <= 1'b0;
			done <= 1'b0;
			sel <= 2'd0;
			uAddr <= UBase;
			vAddr <= VBase;
			yAddr <= YBase;
			occU <= 1'b0;
			occV <= 1'b0;
			fullU <= 1'b0;
			fullV <= 1'b0;
			occY <= 3'd0;
			heldY <= 3'd0;
			lumaHead <= 2'd0;
			lumaTail <= 2'd0;
		end else begin
			if (start && !busy) begin
				busy <= 1'b1;
				done <= 1'b0;
				sel <= 2'd0;
				uAddr <= UBase;
				vAddr <= VBase;
				yAddr <= YBase;
			end else if (rowWritten) begin
				busy <= 1'b0;
				done <= 1'b1;
			end else if (issue) begin
				sel <= sel + 2'd1;
				case (sel)
					2'd0: uAddr <= uAddr + 18'd1;
					2'd1: vAddr <= vAddr + 18'd1;
					default: yAddr <= yAddr + 18'd1;
				endcase
			end
			// take the credit when the read goes out
			if (issue) begin
				case (sel)
					2'd0: occU <= 1'b1;
					2'd1: occV <= 1'b1;
					default: ;
				endcase
			end
			// steer returns by tag
			if (retValid) begin
				case (readRet.plane)
					PlaneU: begin
						chromaWordU <= readRet.word;
						fullU <= 1'b1;
					end
					PlaneV: begin
						chromaWordV <= readRet.word;
						fullV <= 1'b1;
					end
					default: ;
				endcase
			end
			if (retY)
				lumaTail <= lumaTail + 2'd1;
			// credit comes back once the word moves on
			if (chromaMove) begin
				fullU <= 1'b0;
				fullV <= 1'b0;
				occU <= 1'b0;
				occV <= 1'b0;
			end
			if (lumaMove)
				lumaHead <= lumaHead + 2'd1;
			// up on issue or return, down when a word moves on
			occY <= occY + {2'd0, issueY} - {2'd0, lumaMove};
			heldY <= heldY + {2'd0, retY} - {2'd0, lumaMove};
		end
	end

	// luma words enter at the tail
	always_ff @(posedge Clock) begin
		if (retY)
			lumaBuf[lumaTail] <= readRet.word;
	end

endmodule

// ==== hdl/colorPkg.sv ====
package colorPkg;

	// raw 8-bit Y, U or V sample
	typedef logic [7:0] sample_t;

	// accumulator width for filter and conversion
	typedef logic signed [31:0] fixed_t;

	// chroma for one pixel pair, already centred on zero
	typedef struct packed {
		fixed_t uEven;
		fixed_t uOdd;
		fixed_t vEven;
		fixed_t vOdd;
	} chromaPair_t;

	// everything needed to convert one pixel pair
	typedef struct packed {
		sample_t y0;
		sample_t y1;
		chromaPair_t chroma;
	} yuvPair_t;

	typedef struct packed {
		sample_t r;
		sample_t g;
		sample_t b;
	} rgbPixel_t;

	// p0 is the even pixel
	typedef struct packed {
		rgbPixel_t p0;
		rgbPixel_t p1;
	} rgbPair_t;

	// interpolation taps, symmetric around the centre
	localparam fixed_t Tap5 = 32'sd21;
	localparam fixed_t Tap3 = -32'sd52;
	localparam fixed_t Tap1 = 32'sd159;

	// colour matrix in 16.16 fixed point
	localparam fixed_t CoefY = 32'sd76284;
	localparam fixed_t CoefRv = 32'sd104595;
	localparam fixed_t CoefGu = -32'sd25624;
	localparam fixed_t CoefGv = -32'sd53281;
	localparam fixed_t CoefBu = 32'sd132251;

	localparam fixed_t LumaOffset = 32'sd16;
	localparam fixed_t ChromaOffset = 32'sd128;

	// filter result is rounded then divided by 256
	localparam fixed_t FilterRound = 32'sd128;
	localparam int FilterShift = 8;

endpackage

// ==== hdl/sramMapPkg.sv ====
package sramMapPkg;

	// word address into the 256K x 16 SRAM
	typedef logic [17:0] sramAddr_t;

	// hi byte is the even sample or first colour byte
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} sramBytes_t;

	// one SRAM word, seen raw or as two bytes
	typedef union packed {
		logic [15:0] raw;
		sramBytes_t bytes;
	} sramWord_u;

	// which plane a read belongs to
	typedef enum logic [1:0] {
		PlaneY,
		PlaneU,
		PlaneV
	} plane_e;

	// read request, tagged with its plane
	typedef struct packed {
		plane_e plane;
		sramAddr_t address;
	} readReq_t;

	// returned word keeps the tag of its request
	typedef struct packed {
		plane_e plane;
		sramWord_u word;
	} readRet_t;

endpackage
